// File: keep_one_in_n.f
+incdir+.
keep_one_in_n_pkg.sv
keep_one_in_n_settings.sv
keep_sample_sel.sv
keep_vector_sel.sv
keep_stream_gate.sv
keep_one_in_n_top.sv
tb_keep_one_in_n.sv

// File: keep_one_in_n_defs.svh
// Widths, settings register addresses and reset values for the keep-one-in-N decimator
// Included by the package and by any module that decodes the settings bus
`ifndef KEEP_ONE_IN_N_DEFS_SVH
`define KEEP_ONE_IN_N_DEFS_SVH

// Sample word width
`define KOIN_DATA_W 32

// Decimation factor and counter width
`define KOIN_CNT_W 16

// Settings bus
`define KOIN_SET_ADDR_W 8
`define KOIN_SET_DATA_W 32

// Register addresses on the settings bus
`define KOIN_SR_N           129
`define KOIN_SR_VECTOR_MODE 130

// Start in vector mode with N = 1, i.e. pass everything
`define KOIN_N_RESET           1
`define KOIN_VECTOR_MODE_RESET 1

`endif

// File: keep_one_in_n_pkg.sv
// Shared types of the keep-one-in-N decimator
// Modules pull these in with a wildcard import in their header
`default_nettype none

`include "keep_one_in_n_defs.svh"

package keep_one_in_n_pkg;

  ////////////////////////////////////////////////////////////
  // Scalar widths
  ////////////////////////////////////////////////////////////
  typedef logic [`KOIN_DATA_W-1:0]     data_t;
  typedef logic [`KOIN_CNT_W-1:0]      count_t;
  typedef logic [`KOIN_SET_ADDR_W-1:0] set_addr_t;
  typedef logic [`KOIN_SET_DATA_W-1:0] set_data_t;

  ////////////////////////////////////////////////////////////
  // Grouped signals
  ////////////////////////////////////////////////////////////
  // One stream beat
  typedef struct packed {
    data_t data;
    logic  last;
  } beat_t;

  // One settings write
  typedef struct packed {
    logic      stb;
    set_addr_t addr;
    set_data_t data;
  } set_bus_t;

  // Active configuration
  typedef struct packed {
    count_t n;
    logic   vector_mode;
  } keep_cfg_t;

  // Per-beat decision of a selector
  typedef struct packed {
    logic keep;
    logic last;
  } sel_t;

endpackage

`default_nettype wire

// File: keep_one_in_n_settings.sv
// Settings registers of the decimator: N and the vector mode flag
// Written from the strobe/address/data settings bus, active from the next cycle
`timescale 1ns/1ps
`default_nettype none

`include "keep_one_in_n_defs.svh"

module keep_one_in_n_settings
  import keep_one_in_n_pkg::*;
(
  input  wire       ce_clk,
  input  wire       i_arst_n,
  input  set_bus_t  i_set,
  output keep_cfg_t o_cfg
);

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////
  logic   wr_n;
  logic   wr_mode;
  count_t wr_n_val;

  assign wr_n    = i_set.stb && (i_set.addr == set_addr_t'(`KOIN_SR_N));
  assign wr_mode = i_set.stb && (i_set.addr == set_addr_t'(`KOIN_SR_VECTOR_MODE));

  // A zero decimation factor makes no sense, treat it as 1
  always_comb begin
    wr_n_val = i_set.data[`KOIN_CNT_W-1:0];
    if (wr_n_val == '0) begin
      wr_n_val = count_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////
  count_t n_q;
  logic   vector_mode_q;

  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      n_q           <= count_t'(`KOIN_N_RESET);
      vector_mode_q <= 1'(`KOIN_VECTOR_MODE_RESET);
    end else begin
      if (wr_n) begin
        n_q <= wr_n_val;
      end
      if (wr_mode) begin
        vector_mode_q <= i_set.data[0];
      end
    end
  end

  assign o_cfg.n           = n_q;
  assign o_cfg.vector_mode = vector_mode_q;

  // N must never reach the selectors as zero, from reset or from a write
  a_n_nonzero : assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    o_cfg.n != '0);

endmodule

`default_nettype wire

// File: keep_one_in_n_top.sv
// Top level of the keep-one-in-N stream decimator in the ce_clk domain
// Settings registers feed both selectors and the gate; i_clear restarts the counts
`timescale 1ns/1ps
`default_nettype none

module keep_one_in_n_top
  import keep_one_in_n_pkg::*;
(
  input  wire      ce_clk,
  input  wire      i_arst_n,
  input  wire      i_clear,
  // Settings bus
  input  set_bus_t i_set,
  // Input stream
  input  beat_t    i_beat,
  input  wire      i_tvalid,
  output logic     o_tready,
  // Output stream
  output beat_t    o_beat,
  output logic     o_tvalid,
  input  wire      i_tready
);

  keep_cfg_t cfg;
  logic      accept;
  logic      in_last;
  sel_t      sample_sel;
  sel_t      vector_sel;

  ////////////////////////////////////////////////////////////
  // Settings
  ////////////////////////////////////////////////////////////
  keep_one_in_n_settings settings_i (
    .ce_clk   (ce_clk),
    .i_arst_n (i_arst_n),
    .i_set    (i_set),
    .o_cfg    (cfg)
  );

  ////////////////////////////////////////////////////////////
  // Selectors, both watching the same accepted beats
  ////////////////////////////////////////////////////////////
  keep_sample_sel sample_sel_i (
    .ce_clk   (ce_clk),
    .i_arst_n (i_arst_n),
    .i_clear  (i_clear),
    .i_accept (accept),
    .i_last   (in_last),
    .i_cfg    (cfg),
    .o_sel    (sample_sel)
  );

  keep_vector_sel vector_sel_i (
    .ce_clk   (ce_clk),
    .i_arst_n (i_arst_n),
    .i_clear  (i_clear),
    .i_accept (accept),
    .i_last   (in_last),
    .i_cfg    (cfg),
    .o_sel    (vector_sel)
  );

  ////////////////////////////////////////////////////////////
  // Gate and output register
  ////////////////////////////////////////////////////////////
  keep_stream_gate stream_gate_i (
    .ce_clk       (ce_clk),
    .i_arst_n     (i_arst_n),
    .i_beat       (i_beat),
    .i_tvalid     (i_tvalid),
    .o_tready_in  (o_tready),
    .i_cfg        (cfg),
    .i_sample_sel (sample_sel),
    .i_vector_sel (vector_sel),
    .o_accept     (accept),
    .o_in_last    (in_last),
    .o_beat       (o_beat),
    .o_tvalid     (o_tvalid),
    .i_tready_out (i_tready)
  );

endmodule

`default_nettype wire

// File: keep_sample_sel.sv
// Sample mode selector: keeps every Nth accepted beat regardless of packets
// Also counts input packets so that only every Nth input last ends an output packet
`timescale 1ns/1ps
`default_nettype none

module keep_sample_sel
  import keep_one_in_n_pkg::*;
(
  input  wire       ce_clk,
  input  wire       i_arst_n,
  input  wire       i_clear,
  input  wire       i_accept,
  input  wire       i_last,
  input  keep_cfg_t i_cfg,
  output sel_t      o_sel
);

  count_t sample_cnt;
  count_t pkt_cnt;
  count_t n_last;
  logic   sample_wrap;
  logic   pkt_wrap;

  assign n_last = i_cfg.n - count_t'(1);

  // Wrap on >= so a counter left above a newly shrunk N still returns to 0
  assign sample_wrap = (sample_cnt >= n_last);
  assign pkt_wrap    = (pkt_cnt >= n_last);

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sample_cnt <= '0;
      pkt_cnt    <= '0;
    end else if (i_clear) begin
      sample_cnt <= '0;
      pkt_cnt    <= '0;
    end else if (i_accept) begin
      sample_cnt <= sample_wrap ? '0 : sample_cnt + count_t'(1);
      // Packet count moves only on the closing beat of an input packet
      if (i_last) begin
        pkt_cnt <= pkt_wrap ? '0 : pkt_cnt + count_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Decision for the current beat
  ////////////////////////////////////////////////////////////
  assign o_sel.keep = (sample_cnt == n_last);
  assign o_sel.last = i_last && (pkt_cnt == n_last);

  // Counters that start inside the range stay inside it while N holds
  a_cnt_in_range : assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    ($stable(i_cfg.n) && (sample_cnt < i_cfg.n) && (pkt_cnt < i_cfg.n))
    |=> ((sample_cnt < $past(i_cfg.n)) && (pkt_cnt < $past(i_cfg.n))));

endmodule

`default_nettype wire

// File: keep_stream_gate.sv
// Stream gate: valid/ready handshake, mode select between the two selectors
// and a single output register that holds its beat under back-pressure
`timescale 1ns/1ps
`default_nettype none

module keep_stream_gate
  import keep_one_in_n_pkg::*;
(
  input  wire       ce_clk,
  input  wire       i_arst_n,
  // Input stream
  input  beat_t     i_beat,
  input  wire       i_tvalid,
  output logic      o_tready_in,
  // Configuration and selector decisions
  input  keep_cfg_t i_cfg,
  input  sel_t      i_sample_sel,
  input  sel_t      i_vector_sel,
  output logic      o_accept,
  output logic      o_in_last,
  // Output stream
  output beat_t     o_beat,
  output logic      o_tvalid,
  input  wire       i_tready_out
);

  ////////////////////////////////////////////////////////////
  // Handshake and decision
  ////////////////////////////////////////////////////////////
  sel_t  sel_pick;
  logic  load;
  logic  out_valid_q;
  beat_t out_beat_q;

  // Room when empty or when the current beat leaves this cycle
  assign o_tready_in = !out_valid_q || i_tready_out;
  assign o_accept    = i_tvalid && o_tready_in;
  assign o_in_last   = i_beat.last;

  assign sel_pick = i_cfg.vector_mode ? i_vector_sel : i_sample_sel;

  // Dropped beats are accepted too, they just never load
  assign load = o_accept && sel_pick.keep;

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= 1'b1;
    end else if (i_tready_out) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (load) begin
      out_beat_q.data <= i_beat.data;
      out_beat_q.last <= sel_pick.last;
    end
  end

  assign o_beat   = out_beat_q;
  assign o_tvalid = out_valid_q;

  // Held beat must not change until downstream takes it
  a_hold_stable : assert property (@(posedge ce_clk) disable iff (!i_arst_n)
    (o_tvalid && !i_tready_out) |=> (o_tvalid && $stable(o_beat)));

endmodule

`default_nettype wire

// File: keep_vector_sel.sv
// Vector mode selector: keeps every beat of each Nth whole packet
// The packet's own last flag passes through unchanged
`timescale 1ns/1ps
`default_nettype none

module keep_vector_sel
  import keep_one_in_n_pkg::*;
(
  input  wire       ce_clk,
  input  wire       i_arst_n,
  input  wire       i_clear,
  input  wire       i_accept,
  input  wire       i_last,
  input  keep_cfg_t i_cfg,
  output sel_t      o_sel
);

  count_t pkt_cnt;
  count_t n_last;
  logic   pkt_wrap;

  assign n_last   = i_cfg.n - count_t'(1);
  assign pkt_wrap = (pkt_cnt >= n_last);

  ////////////////////////////////////////////////////////////
  // Packet counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pkt_cnt <= '0;
    end else if (i_clear) begin
      pkt_cnt <= '0;
    end else if (i_accept && i_last) begin
      pkt_cnt <= pkt_wrap ? '0 : pkt_cnt + count_t'(1);
    end
  end

  // Whole packet N-1 goes through, everything else is dropped
  assign o_sel.keep = (pkt_cnt == n_last);
  assign o_sel.last = i_last;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the decimator testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_keep_one_in_n

verilator --binary --timing --assert -f keep_one_in_n.f \
  --top-module tb_keep_one_in_n -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: tb_keep_one_in_n.sv
// Testbench for the keep-one-in-N stream decimator
// Drives random packets from an xorshift generator and checks every output beat
// against a reference model of the counting rules
`timescale 1ns/1ps
`default_nettype none

`include "keep_one_in_n_defs.svh"

module tb_keep_one_in_n
  import keep_one_in_n_pkg::*;
;

  localparam int MAX_LEN         = 12;
  localparam int MAX_PKTS        = 300;
  localparam int WATCHDOG_CYCLES = MAX_PKTS * MAX_LEN * 20 + 2000;
  localparam int DRAIN_CYCLES    = 50;

  logic     ce_clk = 1'b0;
  logic     i_arst_n;
  logic     i_clear;
  set_bus_t i_set;
  beat_t    i_beat;
  logic     i_tvalid;
  logic     o_tready;
  beat_t    o_beat;
  logic     o_tvalid;
  logic     i_tready;

  // Reference model state
  int    m_n;
  logic  m_vector;
  int    m_samp;
  int    m_spkt;
  int    m_vpkt;
  logic  m_full;
  beat_t exp_q[$];
  logic  load_seen;
  logic  hold_seen;
  beat_t held_beat;

  // Bookkeeping
  int          err_count;
  int          main_errors;
  int          n_checks;
  int          n_in;
  int          n_out;
  int          n_tests;
  int          err_mark;
  int          in_mark;
  int          out_mark;
  logic        bp_en;
  int unsigned rng_stim;

  always #5 ce_clk = ~ce_clk;

  keep_one_in_n_top keep_one_in_n_top_i (
    .ce_clk   (ce_clk),
    .i_arst_n (i_arst_n),
    .i_clear  (i_clear),
    .i_set    (i_set),
    .i_beat   (i_beat),
    .i_tvalid (i_tvalid),
    .o_tready (o_tready),
    .o_beat   (o_beat),
    .o_tvalid (o_tvalid),
    .i_tready (i_tready)
  );

  ////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////
  function automatic int unsigned xorshift32(input int unsigned s);
    int unsigned x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int unsigned rand_stim();
    rng_stim = xorshift32(rng_stim);
    return rng_stim;
  endfunction

  // Downstream ready, own generator so stimulus order does not matter
  initial begin : ready_driver
    int unsigned rng_rdy;
    rng_rdy  = xorshift32(32'd67206 ^ 32'h9e37_79b9);
    i_tready = 1'b1;
    forever begin
      @(negedge ce_clk);
      rng_rdy  = xorshift32(rng_rdy);
      i_tready = bp_en ? (rng_rdy[3] | rng_rdy[7]) : 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model and output checks
  ////////////////////////////////////////////////////////////
  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] t=%0t %s: got %h expected %h", $time, sig, got, exp);
    err_count++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at t=%0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic model_accept(input beat_t b);
    beat_t kept;
    logic  keep;
    keep      = m_vector ? (m_vpkt == m_n - 1) : (m_samp == m_n - 1);
    kept.data = b.data;
    kept.last = m_vector ? b.last : (b.last && (m_spkt == m_n - 1));
    if (keep) begin
      exp_q.push_back(kept);
      load_seen = 1'b1;
    end
    m_samp = (m_samp + 1 >= m_n) ? 0 : m_samp + 1;
    if (b.last) begin
      m_spkt = (m_spkt + 1 >= m_n) ? 0 : m_spkt + 1;
      m_vpkt = (m_vpkt + 1 >= m_n) ? 0 : m_vpkt + 1;
    end
  endtask

  always @(posedge ce_clk) begin : monitor
    beat_t exp_beat;
    logic  exp_tready;
    if (!i_arst_n) begin
      if (o_tvalid !== 1'b0) begin
        report_mismatch("o_tvalid in reset", 32'(o_tvalid), 32'd0);
      end
      m_n       = `KOIN_N_RESET;
      m_vector  = 1'(`KOIN_VECTOR_MODE_RESET);
      m_samp    = 0;
      m_spkt    = 0;
      m_vpkt    = 0;
      m_full    = 1'b0;
      load_seen = 1'b0;
      hold_seen = 1'b0;
    end else begin
      // Room upstream when the output register is empty or being emptied
      exp_tready = !m_full || i_tready;
      if (o_tvalid !== m_full) begin
        report_mismatch("o_tvalid", 32'(o_tvalid), 32'(m_full));
      end
      if (o_tready !== exp_tready) begin
        report_mismatch("o_tready", 32'(o_tready), 32'(exp_tready));
      end
      if (hold_seen && (o_beat.data !== held_beat.data)) begin
        report_mismatch("o_beat.data held", o_beat.data, held_beat.data);
      end
      if (hold_seen && (o_beat.last !== held_beat.last)) begin
        report_mismatch("o_beat.last held", 32'(o_beat.last), 32'(held_beat.last));
      end
      load_seen = 1'b0;
      hold_seen = 1'b0;
      if (o_tvalid && i_tready) begin
        n_out++;
        if (exp_q.size() == 0) begin
          report_error("output beat appeared that the model did not keep");
        end else begin
          exp_beat = exp_q.pop_front();
          n_checks++;
          if (o_beat.data !== exp_beat.data) begin
            report_mismatch("o_beat.data", o_beat.data, exp_beat.data);
          end
          if (o_beat.last !== exp_beat.last) begin
            report_mismatch("o_beat.last", 32'(o_beat.last), 32'(exp_beat.last));
          end
        end
      end else if (o_tvalid) begin
        hold_seen = 1'b1;
        held_beat = o_beat;
      end
      // Settings decode as the bus defines it
      if (i_set.stb && (i_set.addr == set_addr_t'(`KOIN_SR_N))) begin
        m_n = (i_set.data[15:0] == 16'd0) ? 1 : int'(i_set.data[15:0]);
      end else if (i_set.stb && (i_set.addr == set_addr_t'(`KOIN_SR_VECTOR_MODE))) begin
        m_vector = i_set.data[0];
      end
      if (i_clear) begin
        m_samp = 0;
        m_spkt = 0;
        m_vpkt = 0;
      end else if (i_tvalid && exp_tready) begin
        n_in++;
        model_accept(i_beat);
      end
      // A kept beat fills the register, a taken beat with nothing behind it empties it
      if (load_seen) begin
        m_full = 1'b1;
      end else if (i_tready) begin
        m_full = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks, all start and end on a falling edge
  ////////////////////////////////////////////////////////////
  task automatic write_setting(input int addr, input logic [31:0] data);
    i_set.stb  = 1'b1;
    i_set.addr = set_addr_t'(addr);
    i_set.data = data;
    @(negedge ce_clk);
    i_set = '0;
    @(negedge ce_clk);
  endtask

  task automatic pulse_clear();
    i_clear = 1'b1;
    @(negedge ce_clk);
    i_clear = 1'b0;
    @(negedge ce_clk);
  endtask

  // Packet lengths are multiples of len_unit, up to MAX_LEN
  task automatic send_stream(input int num_pkts, input int len_unit, input int gap_pct);
    int len;
    int span;
    span = MAX_LEN / len_unit;
    if (span < 1) begin
      span = 1;
    end
    for (int p = 0; p < num_pkts; p++) begin
      len = len_unit * (1 + int'(rand_stim() % span));
      for (int b = 0; b < len; b++) begin
        if (int'(rand_stim() % 100) < gap_pct) begin
          i_tvalid = 1'b0;
          repeat (1 + int'(rand_stim() % 3)) @(negedge ce_clk);
        end
        i_beat.data = data_t'(rand_stim());
        i_beat.last = (b == len - 1);
        i_tvalid    = 1'b1;
        @(posedge ce_clk);
        while (!o_tready) @(posedge ce_clk);
        @(negedge ce_clk);
      end
    end
    i_tvalid = 1'b0;
  endtask

  task automatic drain_output();
    int waited;
    bp_en  = 1'b0;
    waited = 0;
    @(posedge ce_clk);
    while ((exp_q.size() != 0 || o_tvalid) && waited < DRAIN_CYCLES) begin
      @(posedge ce_clk);
      waited++;
    end
    @(negedge ce_clk);
    if (exp_q.size() != 0) begin
      $display("ERROR at t=%0t: %0d kept beats never reached the output", $time, exp_q.size());
      main_errors += exp_q.size();
      exp_q.delete();
    end
  endtask

  task automatic start_test();
    err_mark = err_count + main_errors;
    in_mark  = n_in;
    out_mark = n_out;
  endtask

  task automatic finish_test(input string name);
    drain_output();
    n_tests++;
    $display("Test %0d %s: %0d beats in, %0d beats out, %0d errors", n_tests, name,
             n_in - in_mark, n_out - out_mark, err_count + main_errors - err_mark);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin : main
    int n;
    i_arst_n = 1'b0;
    i_clear  = 1'b0;
    i_set    = '0;
    i_beat   = '0;
    i_tvalid = 1'b0;
    bp_en    = 1'b0;
    rng_stim = 32'd67206;
    err_count   = 0;
    main_errors = 0;
    n_checks = 0;
    n_in     = 0;
    n_out    = 0;
    n_tests  = 0;
    repeat (2) @(posedge ce_clk);
    @(negedge ce_clk);
    i_arst_n = 1'b1;
    @(negedge ce_clk);

    // Reset values pass everything through
    start_test();
    send_stream(10, 1, 20);
    finish_test("defaults after reset");

    start_test();
    for (int r = 0; r < 6; r++) begin
      n = 1 + int'(rand_stim() % 8);
      write_setting(`KOIN_SR_N, n);
      write_setting(`KOIN_SR_VECTOR_MODE, 0);
      pulse_clear();
      send_stream(12, (r % 2 == 0) ? 1 : n, 20);
      drain_output();
    end
    finish_test("sample mode");

    start_test();
    for (int r = 0; r < 6; r++) begin
      n = 1 + int'(rand_stim() % 8);
      write_setting(`KOIN_SR_N, n);
      write_setting(`KOIN_SR_VECTOR_MODE, 1);
      pulse_clear();
      send_stream(2 * n + 4, 1, 20);
      drain_output();
    end
    finish_test("vector mode");

    start_test();
    for (int r = 0; r < 4; r++) begin
      n = 1 + int'(rand_stim() % 6);
      write_setting(`KOIN_SR_N, n);
      write_setting(`KOIN_SR_VECTOR_MODE, r % 2);
      pulse_clear();
      bp_en = 1'b1;
      send_stream(12, 1, 40);
      drain_output();
    end
    finish_test("back-pressure");

    // Zero N acts as 1, unknown addresses leave everything alone
    start_test();
    write_setting(`KOIN_SR_N, 0);
    write_setting(`KOIN_SR_VECTOR_MODE, 0);
    pulse_clear();
    send_stream(10, 1, 20);
    drain_output();
    // With N = 3 in sample mode a stray change of N or of the mode shows up
    write_setting(`KOIN_SR_N, 3);
    pulse_clear();
    write_setting(`KOIN_SR_N + 2, 7);
    write_setting(`KOIN_SR_N - 1, 32'h0000_0005);
    send_stream(10, 1, 20);
    finish_test("settings decode");

    start_test();
    write_setting(`KOIN_SR_N, 3);
    pulse_clear();
    send_stream(1, 4, 0);
    drain_output();
    pulse_clear();
    send_stream(8, 1, 20);
    drain_output();
    write_setting(`KOIN_SR_N, 2);
    write_setting(`KOIN_SR_VECTOR_MODE, 1);
    pulse_clear();
    send_stream(1, 1, 0);
    drain_output();
    pulse_clear();
    send_stream(8, 1, 20);
    finish_test("clear");

    $display("Tests run %0d, checks %0d, errors %0d", n_tests, n_checks,
             err_count + main_errors);
    if (err_count + main_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge ce_clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
